// File: gemm_dma.f
logic/gemm_dma_pkg.sv
logic/dma_ctrl_fsm.sv
logic/dma_beat_counter.sv
logic/dma_addr_gen.sv
logic/dma_row_packer.sv
logic/gemm_dma_top.sv
test/gemm_dma_tb.sv

// File: Makefile
# build and run the gemm dma testbench with verilator

TOP := gemm_dma_tb

.PHONY: help test clean

help:
	@echo "make test   build with verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f gemm_dma.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: test/gemm_dma_trace.txt
# gemm dma job trace for a 4 wide array
# test <a_base> <b_base> <c_base> <width> <mem_key> <acc_key>
# row <a|b> <row> <elem0> <elem1> <elem2> <elem3>, elem0 in the low bits
# wr <index> <addr> <data>
# memory word = byte address ^ mem_key, C element i = acc_key + i

# two rows, plain bases
test 00001000 00002000 00003000 2 a5a50000 00000100
row a 0 a5a51000 a5a51004 a5a51008 a5a5100c
row a 1 a5a51010 a5a51014 a5a51018 a5a5101c
row b 1 a5a52010 a5a52014 a5a52018 a5a5201c
wr 0 00003000 00000100
wr 15 0000303c 0000010f

# single row
test 00000040 00000080 000000c0 1 12340000 cafe0000
row a 0 12340040 12340044 12340048 1234004c
row b 0 12340080 12340084 12340088 1234008c
wr 5 000000d4 cafe0005

# full buffer depth
test 00010000 00020000 00030000 64 0f0f0f0f 80000000
row a 63 0f0e0cff 0f0e0cfb 0f0e0cf7 0f0e0cf3
row b 0 0f0d0f0f 0f0d0f0b 0f0d0f07 0f0d0f03
row b 63 0f0d0cff 0f0d0cfb 0f0d0cf7 0f0d0cf3
wr 10 00030028 8000000a

# odd width, A and B close together
test 00008000 00008100 0000a000 5 5a5a5a5a 7ffffff0
row a 4 5a5ada1a 5a5ada1e 5a5ada12 5a5ada16
row b 2 5a5adb7a 5a5adb7e 5a5adb72 5a5adb76
wr 0 0000a000 7ffffff0
wr 15 0000a03c 7fffffff

# back to a single row after the deep job
test 00000000 00000010 00000020 1 ffff0000 00000001
row a 0 ffff0000 ffff0004 ffff0008 ffff000c
row b 0 ffff0010 ffff0014 ffff0018 ffff001c
wr 3 0000002c 00000004

// File: test/gemm_dma_tb.sv
/*
 * gemm dma testbench
 * trace driven jobs against a memory model and a matrix engine model
 */
`timescale 1ns/1ns
`default_nettype none

module gemm_dma_tb
    import gemm_dma_pkg::*;
();

    localparam int SA_WIDTH   = 4;
    localparam int BUF_AW     = 6;
    localparam int BUF_DW     = SA_WIDTH * MEM_DW;
    localparam int CIDX_W     = (SA_WIDTH > 1) ? $clog2(SA_WIDTH * SA_WIDTH) : 1;
    localparam int BUF_ROWS   = 1 << BUF_AW;
    localparam int MAX_BEATS  = 2 * BUF_ROWS * SA_WIDTH;
    localparam int C_ELEMS    = SA_WIDTH * SA_WIDTH;
    localparam int MAX_LAT    = 6;
    localparam int MM_MAX     = 8;
    localparam int CLK_PERIOD = 8;
    localparam int MAX_TESTS  = 16;

    typedef logic [BUF_DW-1:0] buf_row_t;
    typedef logic [63:0]       tag_t;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    mem_addr_t         mat_a_addr_i = '0;
    mem_addr_t         mat_b_addr_i = '0;
    mem_addr_t         mat_c_addr_i = '0;
    mat_dim_t          mat_width_i = '0;
    logic              start_i = 1'b0;
    logic              done_o;
    logic              rd_req_o;
    mem_addr_t         rd_addr_o;
    logic              rd_valid_i = 1'b0;
    mem_word_t         rd_data_i = '0;
    logic              wr_req_o;
    mem_addr_t         wr_addr_o;
    mem_word_t         wr_data_o;
    logic              buf_a_wren_o;
    logic              buf_b_wren_o;
    logic [BUF_AW-1:0] buf_waddr_o;
    buf_row_t          buf_wdata_o;
    logic              mm_start_o;
    logic              mm_done_i = 1'b0;
    logic [CIDX_W-1:0] c_idx_o;
    mem_word_t         c_data_i;

    // trace contents per job
    mem_addr_t t_a [MAX_TESTS];
    mem_addr_t t_b [MAX_TESTS];
    mem_addr_t t_c [MAX_TESTS];
    mat_dim_t  t_n [MAX_TESTS];
    mem_word_t t_mkey [MAX_TESTS];
    mem_word_t t_akey [MAX_TESTS];
    int        num_tests = 0;
    int        wd_cycles = 0;
    bit        load_ok = 1'b0;

    // spot values from the trace
    int        sr_test [$];
    bit        sr_side [$];
    int        sr_row [$];
    buf_row_t  sr_data [$];
    int        sw_test [$];
    int        sw_idx [$];
    mem_addr_t sw_addr [$];
    mem_word_t sw_data [$];

    // current job keys seen by the models
    mem_word_t cur_mkey = '0;
    mem_word_t cur_akey = '0;

    // DUT activity captured for the current job
    mem_addr_t cap_raddr [MAX_BEATS];
    buf_row_t  cap_a [BUF_ROWS];
    buf_row_t  cap_b [BUF_ROWS];
    mem_addr_t cap_waddr [C_ELEMS];
    mem_word_t cap_wdata [C_ELEMS];
    int        rd_seen = 0;
    int        rows_a = 0;
    int        rows_b = 0;
    int        mm_starts = 0;
    int        start_rows = 0;
    int        wr_cnt = 0;
    int        early_writes = 0;
    int        done_cnt = 0;
    bit        mm_done_seen = 1'b0;

    // memory model state
    mem_addr_t pend_addr [$];
    int        pend_due [$];
    int        last_due = 0;
    int        cyc = 0;
    int        mm_delay = 0;

    int        errors = 0;
    int        checks = 0;

    gemm_dma_top #(.SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW)) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .mat_width_i  (mat_width_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .rd_valid_i   (rd_valid_i),
        .rd_data_i    (rd_data_i),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .buf_a_wren_o (buf_a_wren_o),
        .buf_b_wren_o (buf_b_wren_o),
        .buf_waddr_o  (buf_waddr_o),
        .buf_wdata_o  (buf_wdata_o),
        .mm_start_o   (mm_start_o),
        .mm_done_i    (mm_done_i),
        .c_idx_o      (c_idx_o),
        .c_data_i     (c_data_i)
    );

    // accumulator element i holds acc key + i
    assign c_data_i = cur_akey + mem_word_t'(c_idx_o);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory content depends on every address bit
    function automatic mem_word_t mem_fill(input mem_addr_t addr, input mem_word_t key);
        return addr ^ key;
    endfunction

    // row r of a matrix at base with element k in bits k*32 up
    function automatic buf_row_t exp_row(input mem_addr_t base, input int row,
                                         input mem_word_t key);
        buf_row_t r;
        for (int k = 0; k < SA_WIDTH; k++)
            r[k*MEM_DW +: MEM_DW] = mem_fill(base + mem_addr_t'(4 * (row * SA_WIDTH + k)), key);
        return r;
    endfunction

    task automatic check_read(input int beat, input mem_addr_t exp, input mem_addr_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR rd_addr_o beat %0d exp 0x%h got 0x%h", beat, exp, act);
            errors++;
        end
    endtask

    task automatic check_row(input bit side_b, input int row, input buf_row_t exp,
                             input buf_row_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR buf_wdata_o %s row %0d exp 0x%h got 0x%h",
                     side_b ? "B" : "A", row, exp, act);
            errors++;
        end
    endtask

    task automatic check_write(input int idx, input mem_addr_t exp_addr, input mem_word_t exp_data,
                               input mem_addr_t act_addr, input mem_word_t act_data);
        checks++;
        if (exp_addr !== act_addr) begin
            $display("ERROR wr_addr_o %0d exp 0x%h got 0x%h", idx, exp_addr, act_addr);
            errors++;
        end
        if (exp_data !== act_data) begin
            $display("ERROR wr_data_o %0d exp 0x%h got 0x%h", idx, exp_data, act_data);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("ERROR %s count exp 0x%0h got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    // keyword records with # lines skipped
    task automatic load_trace();
        int        fd;
        int        code;
        int        idx;
        int        cycles;
        tag_t      tag;
        tag_t      side;
        mem_word_t w;
        mem_addr_t a;
        buf_row_t  row;
        logic [8*160-1:0] line;
        cycles = 0;
        load_ok = 1'b1;
        fd = $fopen("test/gemm_dma_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            load_ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == tag_t'("#")) begin
                void'($fgets(line, fd));
            end else if (tag == tag_t'("test") && num_tests < MAX_TESTS) begin
                code = $fscanf(fd, "%h %h %h %d %h %h", t_a[num_tests], t_b[num_tests],
                               t_c[num_tests], t_n[num_tests], t_mkey[num_tests],
                               t_akey[num_tests]);
                if (code != 6 || t_n[num_tests] == '0 || int'(t_n[num_tests]) > BUF_ROWS)
                    load_ok = 1'b0;
                // read phase at worst latency, engine, write-back, slack
                cycles += 2 * int'(t_n[num_tests]) * SA_WIDTH * (MAX_LAT + 1)
                          + MM_MAX + C_ELEMS + 100;
                num_tests++;
            end else if (tag == tag_t'("row") && num_tests > 0) begin
                code = $fscanf(fd, "%s %d", side, idx);
                for (int k = 0; k < SA_WIDTH; k++) begin
                    code += $fscanf(fd, "%h", w);
                    row[k*MEM_DW +: MEM_DW] = w;
                end
                if (code != 2 + SA_WIDTH || idx < 0 || idx >= BUF_ROWS)
                    load_ok = 1'b0;
                sr_test.push_back(num_tests - 1);
                sr_side.push_back(side == tag_t'("b"));
                sr_row.push_back(idx);
                sr_data.push_back(row);
            end else if (tag == tag_t'("wr") && num_tests > 0) begin
                code = $fscanf(fd, "%d %h %h", idx, a, w);
                if (code != 3 || idx < 0 || idx >= C_ELEMS)
                    load_ok = 1'b0;
                sw_test.push_back(num_tests - 1);
                sw_idx.push_back(idx);
                sw_addr.push_back(a);
                sw_data.push_back(w);
            end else begin
                $display("trace record not understood");
                load_ok = 1'b0;
            end
        end
        $fclose(fd);
        if (num_tests == 0)
            load_ok = 1'b0;
        if (load_ok)
            wd_cycles = cycles;
        else
            $display("trace file is malformed");
    endtask

    // memory, matrix engine and capture models sampled on the rising edge
    always @(posedge clk) begin : models
        int lat;
        int due;
        if (rst_n) begin
            cyc = cyc + 1;
            if (start_i) begin
                rd_seen = 0;
                rows_a = 0;
                rows_b = 0;
                mm_starts = 0;
                wr_cnt = 0;
                early_writes = 0;
                done_cnt = 0;
                mm_done_seen = 1'b0;
            end
            // in-order responses after 1 to MAX_LAT cycles and at most one per cycle
            if (rd_req_o) begin
                if (rd_seen < MAX_BEATS)
                    cap_raddr[rd_seen] = rd_addr_o;
                rd_seen++;
                lat = int'($urandom % MAX_LAT) + 1;
                due = cyc + lat;
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                pend_addr.push_back(rd_addr_o);
                pend_due.push_back(due);
            end
            if (pend_due.size() > 0 && pend_due[0] == cyc) begin
                rd_valid_i <= 1'b1;
                rd_data_i  <= mem_fill(pend_addr.pop_front(), cur_mkey);
                void'(pend_due.pop_front());
            end else begin
                rd_valid_i <= 1'b0;
            end
            // engine answers after a random delay
            mm_done_i <= 1'b0;
            if (mm_delay > 0) begin
                mm_delay--;
                if (mm_delay == 0)
                    mm_done_i <= 1'b1;
            end
            // only rows written in earlier cycles count here
            if (mm_start_o) begin
                mm_starts++;
                start_rows = rows_a + rows_b;
                mm_delay = int'($urandom % MM_MAX) + 1;
            end
            if (buf_a_wren_o) begin
                cap_a[buf_waddr_o] = buf_wdata_o;
                rows_a++;
            end
            if (buf_b_wren_o) begin
                cap_b[buf_waddr_o] = buf_wdata_o;
                rows_b++;
            end
            // done seen on an earlier edge only
            if (wr_req_o) begin
                if (!mm_done_seen)
                    early_writes++;
                if (wr_cnt < C_ELEMS) begin
                    cap_waddr[wr_cnt] = wr_addr_o;
                    cap_wdata[wr_cnt] = wr_data_o;
                end
                wr_cnt++;
            end
            if (mm_done_i)
                mm_done_seen = 1'b1;
            if (done_o)
                done_cnt++;
        end
    end

    task automatic run_test(input int t);
        int        n;
        int        nb;
        int        errs_before;
        mem_addr_t exp_a;
        n = int'(t_n[t]);
        nb = n * SA_WIDTH;
        errs_before = errors;
        @(posedge clk);
        cur_mkey     <= t_mkey[t];
        cur_akey     <= t_akey[t];
        mat_a_addr_i <= t_a[t];
        mat_b_addr_i <= t_b[t];
        mat_c_addr_i <= t_c[t];
        mat_width_i  <= t_n[t];
        start_i      <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        // counters were cleared on the start edge
        @(posedge clk);
        while (done_cnt == 0)
            @(posedge clk);
        // room for a stray second done
        repeat (4) @(posedge clk);

        check_count("rd_req_o", 2 * nb, rd_seen);
        for (int j = 0; j < 2 * nb && j < rd_seen; j++) begin
            exp_a = (j < nb) ? t_a[t] + mem_addr_t'(4 * j) : t_b[t] + mem_addr_t'(4 * (j - nb));
            check_read(j, exp_a, cap_raddr[j]);
        end
        check_count("buf_a_wren_o", n, rows_a);
        check_count("buf_b_wren_o", n, rows_b);
        for (int r = 0; r < n; r++) begin
            check_row(1'b0, r, exp_row(t_a[t], r, t_mkey[t]), cap_a[r]);
            check_row(1'b1, r, exp_row(t_b[t], r, t_mkey[t]), cap_b[r]);
        end
        check_count("mm_start_o", 1, mm_starts);
        if (mm_starts > 0 && start_rows != 2 * n) begin
            $display("ERROR test %0d: mm_start_o came before all buffer rows were written", t);
            errors++;
        end
        if (early_writes > 0) begin
            $display("ERROR test %0d: memory write issued before mm_done_i", t);
            errors++;
        end
        check_count("wr_req_o", C_ELEMS, wr_cnt);
        for (int i = 0; i < C_ELEMS && i < wr_cnt; i++)
            check_write(i, t_c[t] + mem_addr_t'(4 * i), t_akey[t] + mem_word_t'(i),
                        cap_waddr[i], cap_wdata[i]);
        check_count("done_o", 1, done_cnt);
        // spot values straight from the trace
        for (int i = 0; i < sr_test.size(); i++) begin
            if (sr_test[i] == t)
                check_row(sr_side[i], sr_row[i], sr_data[i],
                          sr_side[i] ? cap_b[sr_row[i]] : cap_a[sr_row[i]]);
        end
        for (int i = 0; i < sw_test.size(); i++) begin
            if (sw_test[i] == t)
                check_write(sw_idx[i], sw_addr[i], sw_data[i],
                            cap_waddr[sw_idx[i]], cap_wdata[sw_idx[i]]);
        end
        $display("test %0d width %0d: %s", t, n, (errors == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        void'($urandom(32'h52cdb99f));
        load_trace();
        if (load_ok) begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            repeat (2) @(posedge clk);
            for (int t = 0; t < num_tests; t++)
                run_test(t);
        end else begin
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // limit follows the trace widths at the worst read latency
    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * CLK_PERIOD);
        $display("timeout, the jobs did not finish within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/gemm_dma_top.sv
/*
 * gemm dma engine
 * loads A and B into the row buffers, runs the matrix engine, stores C
 */
`timescale 1ns/1ns
`default_nettype none

module gemm_dma_top
    import gemm_dma_pkg::*;
#(
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6,
    localparam int BUF_DW  = SA_WIDTH * MEM_DW,
    localparam int CIDX_W  = (SA_WIDTH > 1) ? $clog2(SA_WIDTH * SA_WIDTH) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    // job configuration, stable from start to done
    input  mem_addr_t         mat_a_addr_i,
    input  mem_addr_t         mat_b_addr_i,
    input  mem_addr_t         mat_c_addr_i,
    input  mat_dim_t          mat_width_i,
    input  logic              start_i,
    output logic              done_o,
    // memory read port
    output logic              rd_req_o,
    output mem_addr_t         rd_addr_o,
    input  logic              rd_valid_i,
    input  mem_word_t         rd_data_i,
    // memory write port
    output logic              wr_req_o,
    output mem_addr_t         wr_addr_o,
    output mem_word_t         wr_data_o,
    // row buffers
    output logic              buf_a_wren_o,
    output logic              buf_b_wren_o,
    output logic [BUF_AW-1:0] buf_waddr_o,
    output logic [BUF_DW-1:0] buf_wdata_o,
    // matrix engine
    output logic              mm_start_o,
    input  logic              mm_done_i,
    output logic [CIDX_W-1:0] c_idx_o,
    input  mem_word_t         c_data_i
);

    logic      issue_en;
    logic      write_en;
    logic      issue_last;
    logic      resp_last;
    logic      write_last;
    beat_cnt_t issue_cnt;
    beat_cnt_t resp_cnt;
    beat_cnt_t write_cnt;

    dma_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .issue_last_i (issue_last),
        .resp_last_i  (resp_last),
        .write_last_i (write_last),
        .mm_done_i    (mm_done_i),
        .issue_en_o   (issue_en),
        .write_en_o   (write_en),
        .mm_start_o   (mm_start_o),
        .done_o       (done_o)
    );

    dma_beat_counter #(.SA_WIDTH(SA_WIDTH)) u_cnt (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_width_i  (mat_width_i),
        .start_i      (start_i),
        .issue_en_i   (issue_en),
        .rd_valid_i   (rd_valid_i),
        .write_en_i   (write_en),
        .issue_cnt_o  (issue_cnt),
        .resp_cnt_o   (resp_cnt),
        .write_cnt_o  (write_cnt),
        .issue_last_o (issue_last),
        .resp_last_o  (resp_last),
        .write_last_o (write_last)
    );

    dma_addr_gen #(.SA_WIDTH(SA_WIDTH)) u_addr (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .mat_width_i  (mat_width_i),
        .issue_en_i   (issue_en),
        .issue_cnt_i  (issue_cnt),
        .write_en_i   (write_en),
        .write_cnt_i  (write_cnt),
        .c_data_i     (c_data_i),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .c_idx_o      (c_idx_o)
    );

    dma_row_packer #(.SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW)) u_pack (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_width_i  (mat_width_i),
        .rd_valid_i   (rd_valid_i),
        .rd_data_i    (rd_data_i),
        .resp_cnt_i   (resp_cnt),
        .buf_a_wren_o (buf_a_wren_o),
        .buf_b_wren_o (buf_b_wren_o),
        .buf_waddr_o  (buf_waddr_o),
        .buf_wdata_o  (buf_wdata_o)
    );

endmodule

`default_nettype wire

// File: logic/dma_row_packer.sv
/*
 * dma row packer
 * gathers SA_WIDTH read beats into one buffer row, writes it to A or B
 */
`timescale 1ns/1ns
`default_nettype none

module dma_row_packer
    import gemm_dma_pkg::*;
#(
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6,
    localparam int BUF_DW  = SA_WIDTH * MEM_DW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mat_dim_t          mat_width_i,
    input  logic              rd_valid_i,
    input  mem_word_t         rd_data_i,
    input  beat_cnt_t         resp_cnt_i,
    output logic              buf_a_wren_o,
    output logic              buf_b_wren_o,
    output logic [BUF_AW-1:0] buf_waddr_o,
    output logic [BUF_DW-1:0] buf_wdata_o
);

    logic [BUF_DW-1:0] row_q;
    logic [BUF_DW-1:0] row_d;
    beat_cnt_t         row_idx;
    logic              row_end;
    logic              in_b;

    // position of the incoming beat
    assign row_idx = resp_cnt_i / beat_cnt_t'(SA_WIDTH);
    assign row_end = ((resp_cnt_i % beat_cnt_t'(SA_WIDTH)) == beat_cnt_t'(SA_WIDTH - 1));
    assign in_b    = (row_idx >= beat_cnt_t'(mat_width_i));

    // new beat enters at the top
    // element 0 ends up in the low bits after a full row
    always_comb begin
        row_d = row_q >> MEM_DW;
        row_d[BUF_DW-1 -: MEM_DW] = rd_data_i;
    end

    always_ff @(posedge clk) begin
        if (rd_valid_i)
            row_q <= row_d;
    end

    // write strobe one cycle after the row's last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
        end else begin
            buf_a_wren_o <= rd_valid_i && row_end && !in_b;
            buf_b_wren_o <= rd_valid_i && row_end && in_b;
        end
    end

    // B rows restart at address 0
    always_ff @(posedge clk) begin
        if (rd_valid_i && row_end) begin
            if (in_b)
                buf_waddr_o <= BUF_AW'(row_idx - beat_cnt_t'(mat_width_i));
            else
                buf_waddr_o <= BUF_AW'(row_idx);
        end
    end

    // row register holds the finished row during the write cycle
    assign buf_wdata_o = row_q;

    // every row of A and B needs its own buffer slot
    a_width_fits: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_i |-> (mat_width_i != '0) && (int'(mat_width_i) <= (1 << BUF_AW)));

endmodule

`default_nettype wire

// File: logic/dma_addr_gen.sv
/*
 * dma address generator
 * registered read requests for A and B and write requests for C
 */
`timescale 1ns/1ns
`default_nettype none

module dma_addr_gen
    import gemm_dma_pkg::*;
#(
    parameter int SA_WIDTH = 4,
    localparam int CIDX_W = (SA_WIDTH > 1) ? $clog2(SA_WIDTH * SA_WIDTH) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_addr_t         mat_a_addr_i,
    input  mem_addr_t         mat_b_addr_i,
    input  mem_addr_t         mat_c_addr_i,
    input  mat_dim_t          mat_width_i,
    input  logic              issue_en_i,
    input  beat_cnt_t         issue_cnt_i,
    input  logic              write_en_i,
    input  beat_cnt_t         write_cnt_i,
    input  mem_word_t         c_data_i,
    output logic              rd_req_o,
    output mem_addr_t         rd_addr_o,
    output logic              wr_req_o,
    output mem_addr_t         wr_addr_o,
    output mem_word_t         wr_data_o,
    output logic [CIDX_W-1:0] c_idx_o
);

    beat_cnt_t a_beats;
    beat_cnt_t b_idx;
    logic      in_b;

    // beats of A, B follows right after
    assign a_beats = beat_cnt_t'(mat_width_i) * beat_cnt_t'(SA_WIDTH);
    assign in_b    = (issue_cnt_i >= a_beats);
    assign b_idx   = issue_cnt_i - a_beats;

    // row-major accumulator select, data comes back the same cycle
    assign c_idx_o = write_cnt_i[CIDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req_o <= 1'b0;
            wr_req_o <= 1'b0;
        end else begin
            rd_req_o <= issue_en_i;
            wr_req_o <= write_en_i;
        end
    end

    // 4 bytes per element
    always_ff @(posedge clk) begin
        if (issue_en_i) begin
            if (in_b)
                rd_addr_o <= mat_b_addr_i + (mem_addr_t'(b_idx) << 2);
            else
                rd_addr_o <= mat_a_addr_i + (mem_addr_t'(issue_cnt_i) << 2);
        end
        if (write_en_i) begin
            wr_addr_o <= mat_c_addr_i + (mem_addr_t'(write_cnt_i) << 2);
            wr_data_o <= c_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_beat_counter.sv
/*
 * dma beat counters
 * issue, response and write counts with terminal flags per phase
 */
`timescale 1ns/1ns
`default_nettype none

module dma_beat_counter
    import gemm_dma_pkg::*;
#(
    parameter int SA_WIDTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  mat_dim_t  mat_width_i,
    input  logic      start_i,
    input  logic      issue_en_i,
    input  logic      rd_valid_i,
    input  logic      write_en_i,
    output beat_cnt_t issue_cnt_o,
    output beat_cnt_t resp_cnt_o,
    output beat_cnt_t write_cnt_o,
    output logic      issue_last_o,
    output logic      resp_last_o,
    output logic      write_last_o
);

    beat_cnt_t rd_total;
    beat_cnt_t wr_total;
    beat_cnt_t issue_q;
    beat_cnt_t resp_q;
    beat_cnt_t write_q;

    // A then B, N rows of SA_WIDTH beats each
    assign rd_total = beat_cnt_t'(mat_width_i) * beat_cnt_t'(2 * SA_WIDTH);
    // full C tile
    assign wr_total = beat_cnt_t'(SA_WIDTH * SA_WIDTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= '0;
            resp_q  <= '0;
            write_q <= '0;
        end else if (start_i) begin
            // beat 0 is issued in the start cycle
            issue_q <= issue_en_i ? beat_cnt_t'(1) : '0;
            resp_q  <= '0;
            write_q <= '0;
        end else begin
            if (issue_en_i)
                issue_q <= issue_q + beat_cnt_t'(1);
            if (rd_valid_i)
                resp_q <= resp_q + beat_cnt_t'(1);
            if (write_en_i)
                write_q <= write_q + beat_cnt_t'(1);
        end
    end

    // count still holds the previous job during the start cycle
    assign issue_cnt_o = start_i ? '0 : issue_q;
    assign resp_cnt_o  = resp_q;
    assign write_cnt_o = write_q;

    // issue and write flags mark the final beat, resp flag marks all received
    assign issue_last_o = (issue_cnt_o == rd_total - beat_cnt_t'(1));
    assign resp_last_o  = (resp_q == rd_total);
    assign write_last_o = (write_q == wr_total - beat_cnt_t'(1));

    // in-order memory, a response needs a request already sent
    a_resp_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_i |-> (resp_q < issue_q));

endmodule

`default_nettype wire

// File: logic/dma_ctrl_fsm.sv
/*
 * dma controller FSM
 * steps through read issue, response drain, matrix engine start and wait,
 * C write-back, then a one-cycle done strobe
 */
`timescale 1ns/1ns
`default_nettype none

module dma_ctrl_fsm
    import gemm_dma_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic issue_last_i,
    input  logic resp_last_i,
    input  logic write_last_i,
    input  logic mm_done_i,
    output logic issue_en_o,
    output logic write_en_o,
    output logic mm_start_o,
    output logic done_o
);

    dma_state_t state_q;
    dma_state_t state_d;
    logic       done_q;

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i)
                    state_d = ST_READ;
            end
            ST_READ: begin
                // last request goes out this cycle
                if (issue_last_i)
                    state_d = ST_DRAIN;
            end
            ST_DRAIN: begin
                // all beats in, final row lands in the buffer now
                if (resp_last_i)
                    state_d = ST_MM_START;
            end
            ST_MM_START: begin
                state_d = ST_MM_WAIT;
            end
            ST_MM_WAIT: begin
                // first C write overlaps the done cycle
                // a 1x1 array is finished right there
                if (mm_done_i)
                    state_d = write_last_i ? ST_DONE : ST_WRITE;
            end
            ST_WRITE: begin
                if (write_last_i)
                    state_d = ST_DONE;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // issue starts in the start cycle so the first request is one cycle out
    assign issue_en_o = ((state_q == ST_IDLE) && start_i) || (state_q == ST_READ);

    // write-back starts on the done strobe itself
    assign write_en_o = ((state_q == ST_MM_WAIT) && mm_done_i) || (state_q == ST_WRITE);

    // one cycle after the last buffer row write
    assign mm_start_o = (state_q == ST_MM_START);

    // done trails the last registered write request by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done_q <= 1'b0;
        else
            done_q <= (state_q == ST_DONE);
    end

    assign done_o = done_q;

    // host only starts a job when the engine is free
    a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (state_q == ST_IDLE));

    // matrix engine answers only a start it was given
    a_mm_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i |-> (state_q == ST_MM_WAIT));

endmodule

`default_nettype wire

// File: logic/gemm_dma_pkg.sv
/*
 * gemm dma shared definitions
 * memory word, address and beat count types, controller state encoding
 */
`default_nettype none

package gemm_dma_pkg;

    // one memory beat carries one 32-bit element
    localparam int MEM_DW = 32;

    // memory data word, also one matrix element
    typedef logic [MEM_DW-1:0] mem_word_t;

    // byte address on the memory side
    typedef logic [31:0] mem_addr_t;

    // row count of A and B, zero is illegal
    typedef logic [7:0] mat_dim_t;

    // beats in one phase, 255 rows x SA_WIDTH fits with room
    typedef logic [15:0] beat_cnt_t;

    // controller phases
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_READ     = 3'd1,
        ST_DRAIN    = 3'd2,
        ST_MM_START = 3'd3,
        ST_MM_WAIT  = 3'd4,
        ST_WRITE    = 3'd5,
        ST_DONE     = 3'd6
    } dma_state_t;

endpackage

`default_nettype wire
